// File: design/snoop_pkg.sv
`default_nettype none

package snoop_pkg;

    // ------------------------------------------------------------
    // cache geometry
    // ------------------------------------------------------------
    localparam int WORD_W          = 32;
    localparam int IDX_W           = 3;
    localparam int NUM_SETS        = 1 << IDX_W;
    localparam int WORDS_PER_BLOCK = 2;
    // address minus index, word select and byte offset.
    localparam int TAG_W           = WORD_W - IDX_W - $clog2(WORDS_PER_BLOCK) - 2;

    typedef logic [WORD_W-1:0] word_t;

    // ------------------------------------------------------------
    // address and frame layout
    // ------------------------------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             wsel;   // word within the block.
        logic [1:0]       boff;
    } dcache_addr_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [TAG_W-1:0]            tag;
        word_t [WORDS_PER_BLOCK-1:0] data;
    } dcache_frame_t;

    // ------------------------------------------------------------
    // snoop path
    // ------------------------------------------------------------
    typedef struct packed {
        logic          hit;
        dcache_frame_t frame;
        dcache_addr_t  block_addr;   // word and byte fields at zero.
    } snoop_lookup_t;

    // everything the cache drives toward the coherence bus.
    typedef struct packed {
        logic         cctrans;
        logic         ccwrite;
        dcache_addr_t daddr;
        word_t        dstore;
    } snoop_bus_t;

    typedef struct packed {
        logic             clear_dirty;
        logic             clear_valid;
        logic [IDX_W-1:0] idx;
    } frame_clear_t;

endpackage

`default_nettype wire

// File: design/snoop_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_lookup import snoop_pkg::*; (
    input  dcache_addr_t  snoop_addr,
    input  dcache_frame_t frames [NUM_SETS],
    output snoop_lookup_t lookup
);

    dcache_frame_t sel_frame;
    logic          tag_match;
    dcache_addr_t  block_addr;

    // ------------------------------------------------------------
    // frame select and tag compare
    // ------------------------------------------------------------
    assign sel_frame = frames[snoop_addr.idx];
    assign tag_match = sel_frame.tag == snoop_addr.tag;

    // writeback always starts at the first word of the block.
    always_comb
    begin
        block_addr      = snoop_addr;
        block_addr.wsel = 1'b0;
        block_addr.boff = 2'b00;
    end

    always_comb
    begin
        lookup.hit        = sel_frame.valid & tag_match;   // stale tags never hit.
        lookup.frame      = sel_frame;
        lookup.block_addr = block_addr;
    end

endmodule

`default_nettype wire

// File: design/snoop_writeback_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_writeback_fsm import snoop_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          ccwait,
    input  logic          ccinv,
    input  logic          mem_ready,
    input  snoop_lookup_t lookup,
    output snoop_bus_t    bus_out,
    output frame_clear_t  clear,
    output logic          pr_stall
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        DIRTY_W0,
        DIRTY_W1,
        CLEAN_W0,
        CLEAN_W1,
        TRANS_I,
        TRANS_S
    } snoop_state_t;

    snoop_state_t state;
    snoop_state_t next_state;

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            state <= IDLE;
        else
            state <= next_state;
    end

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (ccwait && lookup.hit && lookup.frame.dirty)
                    next_state = DIRTY_W0;
                else if (ccwait && lookup.hit)
                    next_state = CLEAN_W0;
                else if (ccwait)
                    next_state = WAIT;   // miss.
            end
            WAIT:
            begin
                if (!ccwait)
                    next_state = IDLE;
            end
            DIRTY_W0:
            begin
                if (mem_ready)
                    next_state = DIRTY_W1;
            end
            CLEAN_W0:
            begin
                if (mem_ready)
                    next_state = CLEAN_W1;
            end
            DIRTY_W1,
            CLEAN_W1:
            begin
                if (mem_ready)
                    next_state = ccinv ? TRANS_I : TRANS_S;
            end
            TRANS_I,
            TRANS_S:
            begin
                if (!ccwait)
                    next_state = IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // bus response
    // ------------------------------------------------------------
    always_comb
    begin
        bus_out         = '0;
        bus_out.cctrans = (state != IDLE) && (state != WAIT);
        bus_out.ccwrite = (state == DIRTY_W0) || (state == DIRTY_W1);   // memory takes it too.
        case (state)
            DIRTY_W0,
            CLEAN_W0:
            begin
                bus_out.daddr  = lookup.block_addr;
                bus_out.dstore = lookup.frame.data[0];
            end
            DIRTY_W1,
            CLEAN_W1:
            begin
                bus_out.daddr      = lookup.block_addr;
                bus_out.daddr.wsel = 1'b1;   // block address plus 4.
                bus_out.dstore     = lookup.frame.data[1];
            end
            default:
            begin
                bus_out.daddr  = '0;
                bus_out.dstore = '0;
            end
        endcase
    end

    // dirty always drops after a supply, valid only on invalidation.
    always_comb
    begin
        clear.clear_dirty = (state == TRANS_I) || (state == TRANS_S);
        clear.clear_valid = state == TRANS_I;
        clear.idx         = lookup.block_addr.idx;
    end

    assign pr_stall = bus_out.cctrans;

endmodule

`default_nettype wire

// File: design/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store import snoop_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          fill_en,
    input  dcache_addr_t  fill_addr,
    input  word_t         fill_data [WORDS_PER_BLOCK],
    input  logic          fill_dirty,
    input  frame_clear_t  clear,
    output dcache_frame_t frames [NUM_SETS]
);

    logic                        valid_q [NUM_SETS];
    logic                        dirty_q [NUM_SETS];
    logic [TAG_W-1:0]            tag_q   [NUM_SETS];
    word_t [WORDS_PER_BLOCK-1:0] data_q  [NUM_SETS];

    // ------------------------------------------------------------
    // frame state bits
    // ------------------------------------------------------------
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            for (int i = 0; i < NUM_SETS; i++)
            begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end
        else
        begin
            if (clear.clear_dirty)
                dirty_q[clear.idx] <= 1'b0;
            if (clear.clear_valid)
                valid_q[clear.idx] <= 1'b0;
            // a fill wins over a clear to the same index.
            if (fill_en)
            begin
                valid_q[fill_addr.idx] <= 1'b1;
                dirty_q[fill_addr.idx] <= fill_dirty;
            end
        end
    end

    // ------------------------------------------------------------
    // tag and data
    // ------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (fill_en)
        begin
            tag_q[fill_addr.idx] <= fill_addr.tag;
            for (int w = 0; w < WORDS_PER_BLOCK; w++)
                data_q[fill_addr.idx][w] <= fill_data[w];
        end
    end

    always_comb
    begin
        for (int i = 0; i < NUM_SETS; i++)
        begin
            frames[i].valid = valid_q[i];
            frames[i].dirty = dirty_q[i];
            frames[i].tag   = tag_q[i];
            frames[i].data  = data_q[i];
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_snoop_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_snoop_top import snoop_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         ccwait,
    input  logic         ccinv,
    input  dcache_addr_t ccsnoopaddr,
    input  logic         mem_ready,
    input  logic         fill_en,
    input  dcache_addr_t fill_addr,
    input  word_t        fill_data [WORDS_PER_BLOCK],
    input  logic         fill_dirty,
    output snoop_bus_t   bus_out,
    output logic         pr_stall
);

    dcache_frame_t frames [NUM_SETS];
    snoop_lookup_t lookup;
    frame_clear_t  clear;

    // ------------------------------------------------------------
    // lookup, writeback, frame update
    // ------------------------------------------------------------
    snoop_lookup i_snoop_lookup (
        .snoop_addr (ccsnoopaddr),
        .frames     (frames),
        .lookup     (lookup)
    );

    snoop_writeback_fsm i_snoop_writeback_fsm (
        .CLK       (CLK),
        .nRST      (nRST),
        .ccwait    (ccwait),
        .ccinv     (ccinv),
        .mem_ready (mem_ready),
        .lookup    (lookup),
        .bus_out   (bus_out),
        .clear     (clear),
        .pr_stall  (pr_stall)
    );

    frame_store i_frame_store (
        .CLK        (CLK),
        .nRST       (nRST),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .fill_dirty (fill_dirty),
        .clear      (clear),
        .frames     (frames)
    );

endmodule

`default_nettype wire

// File: test/tb_dcache_snoop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_snoop import snoop_pkg::*; ();

    logic         CLK;
    logic         nRST;
    logic         ccwait;
    logic         ccinv;
    dcache_addr_t ccsnoopaddr;
    logic         mem_ready;
    logic         fill_en;
    dcache_addr_t fill_addr;
    word_t        fill_data [WORDS_PER_BLOCK];
    logic         fill_dirty;
    snoop_bus_t   bus_out;
    logic         pr_stall;

    typedef struct packed {
        logic         is_snoop;
        dcache_addr_t addr;
        word_t        d0;
        word_t        d1;
        logic         dirty;
        logic         inv;
        logic         exp_hit;
    } stim_t;

    // snoop, address, word 0, word 1, fill_dirty, ccinv, expected hit.
    stim_t stim_table [13] = '{
        '{1'b1, 32'h0000_1234, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 32'h0000_0108, 32'ha1a1_0001, 32'ha1a1_0002, 1'b1, 1'b0, 1'b0},
        '{1'b1, 32'h0000_010c, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1},
        '{1'b1, 32'h0000_0108, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1},
        '{1'b0, 32'h0000_0230, 32'hb2b2_0011, 32'hb2b2_0022, 1'b0, 1'b0, 1'b0},
        '{1'b1, 32'h0000_0234, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b1},
        '{1'b1, 32'h0000_0230, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 32'h0000_0f18, 32'hc3c3_0101, 32'hc3c3_0202, 1'b1, 1'b0, 1'b0},
        '{1'b1, 32'h0000_1f18, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0},
        '{1'b1, 32'h0000_0f1c, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1, 1'b1},
        '{1'b1, 32'h0000_0f18, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 32'habcd_e7f8, 32'hd4d4_5555, 32'hd4d4_aaaa, 1'b1, 1'b0, 1'b0},
        '{1'b1, 32'habcd_e7fc, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1}
    };

    dcache_frame_t model [NUM_SETS];   // reference copy of the frame store.
    int            errors;

    dcache_snoop_top i_dcache_snoop_top (
        .CLK         (CLK),
        .nRST        (nRST),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .mem_ready   (mem_ready),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .fill_dirty  (fill_dirty),
        .bus_out     (bus_out),
        .pr_stall    (pr_stall)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [65:0] exp,
                                 input logic [65:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // the processor is stalled exactly while a transfer runs.
    task automatic check_trans(input logic exp_trans);
        compare_value("cctrans", exp_trans, bus_out.cctrans);
        compare_value("pr_stall", exp_trans, pr_stall);
    endtask

    task automatic apply_fill(input stim_t s);
        fill_en      = 1'b1;
        fill_addr    = s.addr;
        fill_data[0] = s.d0;
        fill_data[1] = s.d1;
        fill_dirty   = s.dirty;
        next_cycle();
        fill_en = 1'b0;
        check_trans(1'b0);
        model[s.addr.idx].valid   = 1'b1;
        model[s.addr.idx].dirty   = s.dirty;
        model[s.addr.idx].tag     = s.addr.tag;
        model[s.addr.idx].data[0] = s.d0;
        model[s.addr.idx].data[1] = s.d1;
    endtask

    // bus side of one snoop. samples first, then drives the next cycle.
    task automatic apply_snoop(input stim_t s);
        dcache_frame_t f;
        dcache_addr_t  blk;
        logic          hit;
        int            gap;
        f        = model[s.addr.idx];
        hit      = f.valid && (f.tag == s.addr.tag);
        blk      = s.addr;
        blk.wsel = 1'b0;
        blk.boff = 2'b00;
        if (hit !== s.exp_hit)
        begin
            errors++;
            $display("stimulus entry at address %h disagrees with the frame model", s.addr);
        end
        ccsnoopaddr = s.addr;
        ccinv       = s.inv;
        ccwait      = 1'b1;
        if (!hit)
        begin
            repeat (3)
            begin
                next_cycle();
                check_trans(1'b0);
            end
        end
        else
        begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++)
            begin
                gap      = $urandom_range(3);
                blk.wsel = w[0];
                for (int g = 0; g <= gap; g++)
                begin
                    next_cycle();
                    check_trans(1'b1);
                    compare_value("ccwrite", f.dirty, bus_out.ccwrite);
                    compare_value("daddr", blk, bus_out.daddr);
                    compare_value("dstore", f.data[w], bus_out.dstore);
                    mem_ready = (g == gap);   // word taken on the next edge.
                end
            end
            next_cycle();
            mem_ready = 1'b0;
            check_trans(1'b1);
            compare_value("ccwrite", 1'b0, bus_out.ccwrite);
            model[s.addr.idx].dirty = 1'b0;
            if (s.inv)
                model[s.addr.idx].valid = 1'b0;
        end
        ccwait = 1'b0;
        next_cycle();
        check_trans(1'b0);
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial
    begin
        errors = 0;
        void'($urandom(32'hd439));
        nRST         = 1'b0;
        ccwait       = 1'b0;
        ccinv        = 1'b0;
        ccsnoopaddr  = '0;
        mem_ready    = 1'b0;
        fill_en      = 1'b0;
        fill_addr    = '0;
        fill_data[0] = '0;
        fill_data[1] = '0;
        fill_dirty   = 1'b0;
        for (int i = 0; i < NUM_SETS; i++)
            model[i] = '0;
        repeat (3) @(posedge CLK);
        #1;
        nRST = 1'b1;
        compare_value("bus_out", '0, bus_out);
        compare_value("pr_stall", 1'b0, pr_stall);
        foreach (stim_table[i])
        begin
            if (stim_table[i].is_snoop)
                apply_snoop(stim_table[i]);
            else
                apply_fill(stim_table[i]);
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #($size(stim_table) * 20 * 4);
        $display("watchdog expired before the stimulus table finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/snoop_pkg.sv
design/snoop_lookup.sv
design/snoop_writeback_fsm.sv
design/frame_store.sv
design/dcache_snoop_top.sv
test/tb_dcache_snoop.sv

// File: Bender.yml
package:
  name: dcache_snoop

sources:
  - files:
      - design/snoop_pkg.sv
      - design/snoop_lookup.sv
      - design/snoop_writeback_fsm.sv
      - design/frame_store.sv
      - design/dcache_snoop_top.sv
  - target: test
    files:
      - test/tb_dcache_snoop.sv
